// File: logic/mcu_bus_pkg.sv
`default_nettype none

package mcu_bus_pkg;

	// Bus widths
	typedef logic [15:0] addr_t;	// Byte address from the master
	typedef logic [15:0] data_t;	// One bus word
	typedef logic [3:0]  reg_idx_t;	// Register index, low address nibble
	typedef logic [11:0] block_t;	// Block number, upper address bits
	typedef logic [7:0]  port_t;	// One pin per bit

	// Block numbers, compared against addr[15:4]
	localparam block_t ID_BASE   = 12'hfe0;	// FE00..FE0F
	localparam block_t PORT_BASE = 12'hfe2;	// FE20..FE2F
	localparam block_t TIM_BASE  = 12'hfe4;	// FE40..FE4F

	// ID block
	localparam reg_idx_t ID_REG_CODE = 4'd0;	// Chip code
	localparam reg_idx_t ID_REG_VERS = 4'd1;	// Version number
	localparam reg_idx_t ID_REG_EDIT = 4'd2;	// Edition, two ASCII chars

	// Port block
	localparam reg_idx_t PORT_REG_OUT = 4'd0;	// Output latch
	localparam reg_idx_t PORT_REG_ENB = 4'd1;	// Direction, 1 drives the pin
	localparam reg_idx_t PORT_REG_IN  = 4'd2;	// Synchronized pin state

	// Timer block
	localparam reg_idx_t TIM_REG_CTRL   = 4'd0;	// Bit 0 runs the counter
	localparam reg_idx_t TIM_REG_PERIOD = 4'd1;	// Wrap value
	localparam reg_idx_t TIM_REG_CMPA   = 4'd2;	// Compare A, PWM A threshold
	localparam reg_idx_t TIM_REG_CMPB   = 4'd3;	// Compare B, PWM B threshold
	localparam reg_idx_t TIM_REG_COUNT  = 4'd4;	// Live count, loadable
	localparam reg_idx_t TIM_REG_STAT   = 4'd5;	// Sticky flags, write 1 to clear

endpackage

`default_nettype wire

// File: logic/bus_fabric.sv
`timescale 1ns/1ps
`default_nettype none

module bus_fabric (
	input  mcu_bus_pkg::addr_t bus_addr_i,	// From the external master
	input  mcu_bus_pkg::data_t id_rdata_i,	// Registered, zero when idle
	input  mcu_bus_pkg::data_t port_rdata_i,	// Registered, zero when idle
	input  mcu_bus_pkg::data_t tim_rdata_i,	// Registered, zero when idle
	output logic               id_cs_o,	// ID block addressed
	output logic               port_cs_o,	// Port block addressed
	output logic               tim_cs_o,	// Timer block addressed
	output mcu_bus_pkg::data_t bus_rdata_o	// Combined read data
);
	import mcu_bus_pkg::*;

	block_t blk;	// Upper 12 bits select the block
	logic [2:0] cs_vec;	// Selects gathered for checking
	logic [2:0] busy_vec;	// Which peripherals drive nonzero data

	assign blk = bus_addr_i[15:4];

	// Address only; strobes are qualified inside each block
	assign id_cs_o   = (blk == ID_BASE);
	assign port_cs_o = (blk == PORT_BASE);
	assign tim_cs_o  = (blk == TIM_BASE);

	// Idle blocks return zero, so a plain OR merges them
	assign bus_rdata_o = id_rdata_i | port_rdata_i | tim_rdata_i;

	assign cs_vec   = {id_cs_o, port_cs_o, tim_cs_o};
	assign busy_vec = {|id_rdata_i, |port_rdata_i, |tim_rdata_i};

	// Ignored until the master and the peripheral registers are defined
	always_comb begin
		assert final ($isunknown(cs_vec) || $onehot0(cs_vec))
			else $error("bus_fabric: overlapping block selects");
		// A second nonzero source would corrupt the OR
		assert final ($isunknown(busy_vec) || $onehot0(busy_vec))
			else $error("bus_fabric: more than one block returns read data");
	end

endmodule

`default_nettype wire

// File: logic/id_register.sv
`timescale 1ns/1ps
`default_nettype none

module id_register #(
	parameter mcu_bus_pkg::data_t ID_CODE = 16'h1150,	// Chip code
	parameter mcu_bus_pkg::data_t VERSION = 16'h0148,	// BCD-style version
	parameter mcu_bus_pkg::data_t EDITION = 16'h5343	// Two chars, "SC"
) (
	input  logic                  clk,
	input  logic                  reset_i,
	input  logic                  cs_i,	// Block select from the fabric
	input  logic                  rd_i,	// Read strobe
	input  mcu_bus_pkg::reg_idx_t reg_idx_i,	// Word inside the block
	output mcu_bus_pkg::data_t    rdata_o	// Zero except after a read
);
	import mcu_bus_pkg::*;

	data_t rd_mux;	// Addressed constant

	always_comb begin
		case (reg_idx_i)
			ID_REG_CODE: rd_mux = ID_CODE;
			ID_REG_VERS: rd_mux = VERSION;
			ID_REG_EDIT: rd_mux = EDITION;
			default:     rd_mux = '0;	// Unused indices
		endcase
	end

	// One cycle of latency; no write path at all
	always_ff @(posedge clk) begin
		if (reset_i) begin
			rdata_o <= '0;
		end else begin
			rdata_o <= (cs_i && rd_i) ? rd_mux : '0;	// Drops back to zero
		end
	end

endmodule

`default_nettype wire

// File: logic/gpio_port.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_port #(
	parameter bit INIT_HIZ = 1'b1	// Pins start as inputs
) (
	input  logic                  clk,
	input  logic                  reset_i,
	input  logic                  cs_i,	// Block select from the fabric
	input  logic                  rd_i,	// Read strobe
	input  logic                  wr_i,	// Write strobe
	input  mcu_bus_pkg::reg_idx_t reg_idx_i,	// Register inside the block
	input  mcu_bus_pkg::data_t    wdata_i,	// Only the low byte is stored
	input  mcu_bus_pkg::port_t    port_in_i,	// Asynchronous pin levels
	output mcu_bus_pkg::port_t    port_out_o,	// Output latch
	output mcu_bus_pkg::port_t    port_oe_o,	// Per-pin drive enable
	output mcu_bus_pkg::data_t    rdata_o	// Zero except after a read
);
	import mcu_bus_pkg::*;

	localparam port_t ENB_RESET = INIT_HIZ ? '0 : '1;	// Direction after reset

	port_t out_q;	// OUT register
	port_t enb_q;	// ENB register
	port_t sync1_q;	// First synchronizer stage
	port_t sync2_q;	// IN register
	port_t rd_mux;	// Addressed byte
	logic  wr_sel;
	logic  rd_sel;

	assign wr_sel = cs_i & wr_i;
	assign rd_sel = cs_i & rd_i;

	// Control registers, written from the low data byte
	always_ff @(posedge clk) begin
		if (reset_i) begin
			out_q <= '0;
			enb_q <= ENB_RESET;
		end else if (wr_sel) begin
			case (reg_idx_i)
				PORT_REG_OUT: out_q <= wdata_i[7:0];
				PORT_REG_ENB: enb_q <= wdata_i[7:0];
				default: ;	// IN is read-only
			endcase
		end
	end

	// Two-flop synchronizer on the pins
	always_ff @(posedge clk) begin
		sync1_q <= port_in_i;
		sync2_q <= sync1_q;	// Settled after two edges
	end

	always_comb begin
		case (reg_idx_i)
			PORT_REG_OUT: rd_mux = out_q;
			PORT_REG_ENB: rd_mux = enb_q;
			PORT_REG_IN:  rd_mux = sync2_q;
			default:      rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			rdata_o <= '0;
		end else begin
			rdata_o <= rd_sel ? {8'h00, rd_mux} : '0;	// Zero-extended
		end
	end

	assign port_out_o = out_q;
	assign port_oe_o  = enb_q;

	// The master never reads and writes in the same cycle
	assert property (@(posedge clk) disable iff (reset_i) !(cs_i && rd_i && wr_i))
		else $error("gpio_port: read and write strobes together");

endmodule

`default_nettype wire

// File: logic/pwm_timer.sv
`timescale 1ns/1ps
`default_nettype none

module pwm_timer (
	input  logic                  clk,
	input  logic                  reset_i,
	input  logic                  cs_i,	// Block select from the fabric
	input  logic                  rd_i,	// Read strobe
	input  logic                  wr_i,	// Write strobe
	input  mcu_bus_pkg::reg_idx_t reg_idx_i,	// Register inside the block
	input  mcu_bus_pkg::data_t    wdata_i,	// Write data
	output logic                  pwm_a_o,	// High while count < CMPA
	output logic                  pwm_b_o,	// High while count < CMPB
	output mcu_bus_pkg::data_t    rdata_o	// Zero except after a read
);
	import mcu_bus_pkg::*;

	logic       run_q;	// CTRL bit 0
	data_t      period_q;	// Counter wraps after this value
	data_t      cmpa_q;
	data_t      cmpb_q;
	data_t      count_q;
	logic [2:0] stat_q;	// {cmpb, cmpa, ovf}
	logic [2:0] stat_set;	// Events this cycle
	logic [2:0] stat_clr;	// Write-1-to-clear mask
	data_t      rd_mux;
	logic       wr_sel;
	logic       rd_sel;
	logic       wrap;	// Last count of the period

	assign wr_sel = cs_i & wr_i;
	assign rd_sel = cs_i & rd_i;
	assign wrap   = run_q & (count_q == period_q);

	// Configuration registers
	always_ff @(posedge clk) begin
		if (reset_i) begin
			run_q    <= 1'b0;
			period_q <= 16'hffff;	// Full 16-bit range
			cmpa_q   <= '0;
			cmpb_q   <= '0;
		end else if (wr_sel) begin
			case (reg_idx_i)
				TIM_REG_CTRL:   run_q    <= wdata_i[0];
				TIM_REG_PERIOD: period_q <= wdata_i;
				TIM_REG_CMPA:   cmpa_q   <= wdata_i;
				TIM_REG_CMPB:   cmpb_q   <= wdata_i;
				default: ;	// COUNT and STAT handled below
			endcase
		end
	end

	// Counter; a bus load beats counting
	always_ff @(posedge clk) begin
		if (reset_i) begin
			count_q <= '0;
		end else if (wr_sel && (reg_idx_i == TIM_REG_COUNT)) begin
			count_q <= wdata_i;
		end else if (wrap) begin
			count_q <= '0;
		end else if (run_q) begin
			count_q <= count_q + 16'd1;
		end
	end

	// Flags only set while running
	assign stat_set = {
		run_q & (count_q == cmpb_q),
		run_q & (count_q == cmpa_q),
		wrap
	};
	assign stat_clr = (wr_sel && (reg_idx_i == TIM_REG_STAT)) ? wdata_i[2:0] : 3'b000;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			stat_q <= '0;
		end else begin
			stat_q <= (stat_q | stat_set) & ~stat_clr;	// Clear wins
		end
	end

	always_comb begin
		case (reg_idx_i)
			TIM_REG_CTRL:   rd_mux = {15'h0000, run_q};
			TIM_REG_PERIOD: rd_mux = period_q;
			TIM_REG_CMPA:   rd_mux = cmpa_q;
			TIM_REG_CMPB:   rd_mux = cmpb_q;
			TIM_REG_COUNT:  rd_mux = count_q;
			TIM_REG_STAT:   rd_mux = {13'h0000, stat_q};
			default:        rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			rdata_o <= '0;
		end else begin
			rdata_o <= rd_sel ? rd_mux : '0;
		end
	end

	// Duty cycle is the compare value in clocks
	assign pwm_a_o = run_q & (count_q < cmpa_q);
	assign pwm_b_o = run_q & (count_q < cmpb_q);

	// A stopped timer keeps its output quiet
	assert property (@(posedge clk) disable iff (reset_i) !run_q |-> !pwm_a_o)
		else $error("pwm_timer: pwm_a_o high while stopped");

endmodule

`default_nettype wire

// File: logic/periph_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module periph_subsystem #(
	parameter bit                 INIT_HIZ = 1'b1,	// Port pins start as inputs
	parameter mcu_bus_pkg::data_t ID_CODE  = 16'h1150,	// Chip code
	parameter mcu_bus_pkg::data_t VERSION  = 16'h0148,	// Version number
	parameter mcu_bus_pkg::data_t EDITION  = 16'h5343	// "SC"
) (
	input  logic               clk,
	input  logic               reset_i,
	input  logic               bus_rd_i,	// One-cycle read strobe
	input  logic               bus_wr_i,	// One-cycle write strobe
	input  mcu_bus_pkg::addr_t bus_addr_i,
	input  mcu_bus_pkg::data_t bus_wdata_i,
	input  mcu_bus_pkg::port_t port_in_i,	// Pin levels
	output mcu_bus_pkg::data_t bus_rdata_o,	// Valid the cycle after a read
	output mcu_bus_pkg::port_t port_out_o,
	output mcu_bus_pkg::port_t port_oe_o,
	output logic               pwm_a_o,
	output logic               pwm_b_o
);
	import mcu_bus_pkg::*;

	logic     id_cs;
	logic     port_cs;
	logic     tim_cs;
	data_t    id_rdata;
	data_t    port_rdata;
	data_t    tim_rdata;
	reg_idx_t reg_idx;	// Shared by every block

	assign reg_idx = bus_addr_i[3:0];

	bus_fabric bus_fabric_i (
		.bus_addr_i   (bus_addr_i),
		.id_rdata_i   (id_rdata),
		.port_rdata_i (port_rdata),
		.tim_rdata_i  (tim_rdata),
		.id_cs_o      (id_cs),
		.port_cs_o    (port_cs),
		.tim_cs_o     (tim_cs),
		.bus_rdata_o  (bus_rdata_o)
	);

	id_register #(
		.ID_CODE (ID_CODE),
		.VERSION (VERSION),
		.EDITION (EDITION)
	) id_register_i (
		.clk       (clk),
		.reset_i   (reset_i),
		.cs_i      (id_cs),
		.rd_i      (bus_rd_i),	// Writes never reach it
		.reg_idx_i (reg_idx),
		.rdata_o   (id_rdata)
	);

	gpio_port #(
		.INIT_HIZ (INIT_HIZ)
	) gpio_port_i (
		.clk        (clk),
		.reset_i    (reset_i),
		.cs_i       (port_cs),
		.rd_i       (bus_rd_i),
		.wr_i       (bus_wr_i),
		.reg_idx_i  (reg_idx),
		.wdata_i    (bus_wdata_i),
		.port_in_i  (port_in_i),
		.port_out_o (port_out_o),
		.port_oe_o  (port_oe_o),
		.rdata_o    (port_rdata)
	);

	pwm_timer pwm_timer_i (
		.clk       (clk),
		.reset_i   (reset_i),
		.cs_i      (tim_cs),
		.rd_i      (bus_rd_i),
		.wr_i      (bus_wr_i),
		.reg_idx_i (reg_idx),
		.wdata_i   (bus_wdata_i),
		.pwm_a_o   (pwm_a_o),
		.pwm_b_o   (pwm_b_o),
		.rdata_o   (tim_rdata)
	);

endmodule

`default_nettype wire

// File: tests/tb_periph_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_periph_subsystem #(
	parameter bit                 INIT_HIZ = 1'b1,	// Pins start as inputs
	parameter mcu_bus_pkg::data_t ID_CODE  = 16'h1150,
	parameter mcu_bus_pkg::data_t VERSION  = 16'h0148,
	parameter mcu_bus_pkg::data_t EDITION  = "SC"	// Two ASCII chars
);
	import mcu_bus_pkg::*;

	localparam int IN_TIMEOUT = 8;	// Reads allowed for the pin synchronizer

	logic   clk;
	logic   reset;
	logic   bus_rd;
	logic   bus_wr;
	addr_t  bus_addr;
	data_t  bus_wdata;
	port_t  port_in;
	data_t  bus_rdata;
	port_t  port_out;
	port_t  port_oe;
	logic   pwm_a;
	logic   pwm_b;
	integer seed;	// $random state

	periph_subsystem #(
		.INIT_HIZ (INIT_HIZ),
		.ID_CODE  (ID_CODE),
		.VERSION  (VERSION),
		.EDITION  (EDITION)
	) periph_subsystem_i (
		.clk         (clk),
		.reset_i     (reset),
		.bus_rd_i    (bus_rd),
		.bus_wr_i    (bus_wr),
		.bus_addr_i  (bus_addr),
		.bus_wdata_i (bus_wdata),
		.port_in_i   (port_in),
		.bus_rdata_o (bus_rdata),
		.port_out_o  (port_out),
		.port_oe_o   (port_oe),
		.pwm_a_o     (pwm_a),
		.pwm_b_o     (pwm_b)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;	// 100 ns period
	end

	// Block number in the upper bits, register in the low nibble
	function automatic addr_t reg_addr(input block_t blk, input reg_idx_t idx);
		return {blk, idx};
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check(input string name, input data_t actual, input data_t expected);
		if (actual !== expected) begin
			$display("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
			abort_run("Stopping at the first wrong value");
		end
	endtask

	// Called 10 ns after an edge, returns at the same phase
	task automatic bus_write(input addr_t addr, input data_t data);
		bus_addr  = addr;
		bus_wdata = data;
		bus_wr    = 1'b1;
		@(posedge clk);	// Write lands on this edge
		#10;
		bus_wr = 1'b0;
	endtask

	task automatic bus_read(input addr_t addr, output data_t data);
		bus_addr = addr;
		bus_rd   = 1'b1;
		@(posedge clk);	// Strobe sampled here
		#10;
		bus_rd = 1'b0;
		data   = bus_rdata;	// Held until the next edge
	endtask

	task automatic read_expect(input string name, input addr_t addr, input data_t expected);
		data_t value;
		bus_read(addr, value);
		check(name, value, expected);
	endtask

	// Read data must fall back to zero one cycle later
	task automatic check_idle_bus();
		@(posedge clk);
		#10;
		check("bus_rdata_o (idle)", bus_rdata, 16'h0000);
	endtask

	task automatic wait_port_in(input port_t expected);
		data_t value;
		int    tries;
		tries = 1;
		bus_read(reg_addr(PORT_BASE, PORT_REG_IN), value);
		while (value !== {8'h00, expected}) begin
			if (tries >= IN_TIMEOUT) begin
				abort_run("Timeout: the IN register never showed the pin levels");
			end else begin
				tries++;
				bus_read(reg_addr(PORT_BASE, PORT_REG_IN), value);
			end
		end
	endtask

	task automatic reset_values_test();
		check("port_oe_o", {8'h00, port_oe}, INIT_HIZ ? 16'h0000 : 16'h00ff);
		check("port_out_o", {8'h00, port_out}, 16'h0000);
		check("pwm_a_o", {15'h0000, pwm_a}, 16'h0000);
		check("pwm_b_o", {15'h0000, pwm_b}, 16'h0000);
		check("bus_rdata_o", bus_rdata, 16'h0000);
		read_expect("bus_rdata_o (CTRL)", reg_addr(TIM_BASE, TIM_REG_CTRL), 16'h0000);
		read_expect("bus_rdata_o (PERIOD)", reg_addr(TIM_BASE, TIM_REG_PERIOD), 16'hffff);
		read_expect("bus_rdata_o (CMPA)", reg_addr(TIM_BASE, TIM_REG_CMPA), 16'h0000);
		read_expect("bus_rdata_o (CMPB)", reg_addr(TIM_BASE, TIM_REG_CMPB), 16'h0000);
		read_expect("bus_rdata_o (COUNT)", reg_addr(TIM_BASE, TIM_REG_COUNT), 16'h0000);
		read_expect("bus_rdata_o (STAT)", reg_addr(TIM_BASE, TIM_REG_STAT), 16'h0000);
	endtask

	task automatic id_block_test();
		read_expect("bus_rdata_o (ID code)", reg_addr(ID_BASE, ID_REG_CODE), ID_CODE);
		check_idle_bus();
		read_expect("bus_rdata_o (ID version)", reg_addr(ID_BASE, ID_REG_VERS), VERSION);
		read_expect("bus_rdata_o (ID edition)", reg_addr(ID_BASE, ID_REG_EDIT), EDITION);
		read_expect("bus_rdata_o (ID index 3)", reg_addr(ID_BASE, 4'd3), 16'h0000);
		read_expect("bus_rdata_o (unmapped)", 16'h1000, 16'h0000);	// Outside every block
		bus_write(reg_addr(ID_BASE, ID_REG_CODE), 16'hdead);
		check("bus_rdata_o (after write)", bus_rdata, 16'h0000);	// Writes return nothing
		read_expect("bus_rdata_o (ID code kept)", reg_addr(ID_BASE, ID_REG_CODE), ID_CODE);
	endtask

	task automatic port_register_test();
		logic [31:0] rnd;
		data_t       wval;
		port_t       pins;
		int          i;
		for (i = 0; i < 4; i++) begin
			rnd  = $random(seed);
			wval = rnd[15:0];	// Upper byte is dropped by the port
			bus_write(reg_addr(PORT_BASE, PORT_REG_OUT), wval);
			check("port_out_o", {8'h00, port_out}, {8'h00, wval[7:0]});
			read_expect("bus_rdata_o (OUT)", reg_addr(PORT_BASE, PORT_REG_OUT),
				{8'h00, wval[7:0]});
			wval = rnd[31:16];
			bus_write(reg_addr(PORT_BASE, PORT_REG_ENB), wval);
			check("port_oe_o", {8'h00, port_oe}, {8'h00, wval[7:0]});
			read_expect("bus_rdata_o (ENB)", reg_addr(PORT_BASE, PORT_REG_ENB),
				{8'h00, wval[7:0]});
		end
		for (i = 0; i < 4; i++) begin
			rnd     = $random(seed);
			pins    = rnd[7:0];
			port_in = pins;	// Two edges through the synchronizer
			wait_port_in(pins);
		end
	endtask

	task automatic pwm_test();
		data_t cmpa;
		data_t cmpb;
		int    a_high;
		int    b_high;
		int    i;
		cmpa   = 16'd3;
		cmpb   = 16'd7;
		a_high = 0;
		b_high = 0;
		bus_write(reg_addr(TIM_BASE, TIM_REG_PERIOD), 16'd9);	// Counts 0 to 9
		bus_write(reg_addr(TIM_BASE, TIM_REG_CMPA), cmpa);
		bus_write(reg_addr(TIM_BASE, TIM_REG_CMPB), cmpb);
		bus_write(reg_addr(TIM_BASE, TIM_REG_CTRL), 16'h0001);	// Start from count 0
		for (i = 0; i < 10; i++) begin	// One full period
			if (pwm_a) begin
				a_high++;
			end
			if (pwm_b) begin
				b_high++;
			end
			@(posedge clk);
			#10;
		end
		check("pwm_a_o high cycles", a_high[15:0], cmpa);
		check("pwm_b_o high cycles", b_high[15:0], cmpb);
		bus_write(reg_addr(TIM_BASE, TIM_REG_CTRL), 16'h0000);	// Stop
		check("pwm_a_o (stopped)", {15'h0000, pwm_a}, 16'h0000);
		check("pwm_b_o (stopped)", {15'h0000, pwm_b}, 16'h0000);
	endtask

	task automatic flag_test();
		logic [31:0] rnd;
		// Overflow, compare A and compare B all passed during the run
		read_expect("bus_rdata_o (STAT after run)", reg_addr(TIM_BASE, TIM_REG_STAT), 16'h0007);
		bus_write(reg_addr(TIM_BASE, TIM_REG_STAT), 16'h0007);	// Write 1 to clear
		read_expect("bus_rdata_o (STAT cleared)", reg_addr(TIM_BASE, TIM_REG_STAT), 16'h0000);
		rnd = $random(seed);
		bus_write(reg_addr(TIM_BASE, TIM_REG_COUNT), rnd[15:0]);
		read_expect("bus_rdata_o (COUNT)", reg_addr(TIM_BASE, TIM_REG_COUNT), rnd[15:0]);
		read_expect("bus_rdata_o (COUNT held)", reg_addr(TIM_BASE, TIM_REG_COUNT), rnd[15:0]);
	endtask

	initial begin
		seed      = 55;
		reset     = 1'b1;
		bus_rd    = 1'b0;
		bus_wr    = 1'b0;
		bus_addr  = '0;
		bus_wdata = '0;
		port_in   = '0;
		repeat (3) @(posedge clk);	// Three reset cycles
		#10;
		reset = 1'b0;
		reset_values_test();
		id_block_test();
		port_register_test();
		pwm_test();
		flag_test();
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
logic/mcu_bus_pkg.sv
logic/bus_fabric.sv
logic/id_register.sv
logic/gpio_port.sv
logic/pwm_timer.sv
logic/periph_subsystem.sv
tests/tb_periph_subsystem.sv

// File: Makefile
# Verilator build for the peripheral subsystem

VERILATOR  ?= verilator
TOP        ?= tb_periph_subsystem
RTL_TOP    ?= periph_subsystem
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing

SOURCES := $(wildcard logic/*.sv tests/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# $fatal in the testbench gives a nonzero exit status
run: build
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
